// ==== logic/sprite_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared sizes and apb register map for the sprite
// overlay, imported by every rtl block that needs them
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package sprite_pkg;

    // sprite geometry
    localparam int spr_size = 8;                 // width and height in pixels
    localparam int spr_aw   = $clog2(spr_size);  // bits to index a row or column

    // raster coordinates, signed so blanking runs negative
    localparam int cordw = 16;

    // colour
    localparam int colr_w = 4;         // one channel
    localparam int rgb_w  = 3 * colr_w; // red, green, blue packed high to low

    // apb register map, byte offsets
    localparam int apb_aw = 6;
    localparam logic [apb_aw-1:0] reg_ctrl = 6'h00;  // bit 0 enable
    localparam logic [apb_aw-1:0] reg_posx = 6'h04;  // sprite left edge
    localparam logic [apb_aw-1:0] reg_posy = 6'h08;  // sprite top edge
    localparam logic [apb_aw-1:0] reg_colr = 6'h0C;  // 12-bit rgb
    localparam logic [apb_aw-1:0] reg_bmp0 = 6'h10;  // row n at +4*n, bit 7 leftmost

endpackage

// ==== logic/display_timings.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// raster timing generator, registered coordinates,
// syncs, data enable and line/frame strobes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module display_timings
    import sprite_pkg::*;
#(
    parameter int h_res  = 640,  // active pixels per line
    parameter int h_fp   = 16,   // front porch
    parameter int h_sync = 96,   // sync width
    parameter int h_bp   = 48,   // back porch
    parameter int v_res  = 480,  // active lines
    parameter int v_fp   = 10,
    parameter int v_sync = 2,
    parameter int v_bp   = 33
) (
    input  wire logic clk_pix,
    input  wire logic rst_n,
    output logic signed [cordw-1:0] sx,  // horizontal, 0 at first active pixel
    output logic signed [cordw-1:0] sy,  // vertical, 0 at first active line
    output logic hsync,                  // active high
    output logic vsync,
    output logic de,                     // active video
    output logic line,                   // one cycle at line start
    output logic frame                   // one cycle at frame start
);

    localparam int h_blank = h_fp + h_sync + h_bp;
    localparam int v_blank = v_fp + v_sync + v_bp;

    // counter landmarks, blanking sits before active video
    localparam logic signed [cordw-1:0] h_sta  = cordw'(-h_blank);
    localparam logic signed [cordw-1:0] hs_sta = cordw'(h_fp - h_blank);
    localparam logic signed [cordw-1:0] hs_end = cordw'(h_fp + h_sync - h_blank);
    localparam logic signed [cordw-1:0] ha_end = cordw'(h_res - 1);
    localparam logic signed [cordw-1:0] v_sta  = cordw'(-v_blank);
    localparam logic signed [cordw-1:0] vs_sta = cordw'(v_fp - v_blank);
    localparam logic signed [cordw-1:0] vs_end = cordw'(v_fp + v_sync - v_blank);
    localparam logic signed [cordw-1:0] va_end = cordw'(v_res - 1);

    logic signed [cordw-1:0] sx_nxt;
    logic signed [cordw-1:0] sy_nxt;

    // next position, decoded outputs follow from it so all stay aligned
    always_comb begin
        if (sx == ha_end) begin
            sx_nxt = h_sta;                                  // wrap to blanking
            sy_nxt = (sy == va_end) ? v_sta : sy + cordw'(1);
        end else begin
            sx_nxt = sx + cordw'(1);
            sy_nxt = sy;
        end
    end

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            sx    <= h_sta;
            sy    <= v_sta;
            hsync <= 1'b0;
            vsync <= 1'b0;
            de    <= 1'b0;
            line  <= 1'b0;
            frame <= 1'b0;
        end else begin
            sx    <= sx_nxt;
            sy    <= sy_nxt;
            hsync <= (sx_nxt >= hs_sta) && (sx_nxt < hs_end);
            vsync <= (sy_nxt >= vs_sta) && (sy_nxt < vs_end);
            de    <= (sx_nxt >= 0) && (sy_nxt >= 0);
            line  <= (sx_nxt == h_sta);
            frame <= (sx_nxt == h_sta) && (sy_nxt == v_sta);  // first blanking line
        end
    end

    // horizontal counter must always wrap at the end of active video
    sx_in_line: assert property (@(posedge clk_pix) disable iff (!rst_n)
        sx <= ha_end);

endmodule

// ==== logic/sprite_regs.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// apb register file for the sprite whose working copies
// read back over apb and whose shadow copies move on frame
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module sprite_regs
    import sprite_pkg::*;
(
    input  wire logic clk_pix,
    input  wire logic rst_n,
    input  wire logic psel,
    input  wire logic penable,
    input  wire logic pwrite,
    input  wire logic [apb_aw-1:0] paddr,
    input  wire logic [31:0] pwdata,
    input  wire logic frame,                      // shadow load strobe
    output logic [31:0] prdata,
    output logic pready,
    output logic pslverr,
    output logic spr_en,
    output logic signed [cordw-1:0] spr_x,
    output logic signed [cordw-1:0] spr_y,
    output logic [rgb_w-1:0] spr_colr,
    output logic [spr_size*spr_size-1:0] spr_bitmap  // row n at [8n+7:8n]
);

    // working set that apb reads and writes
    logic en_r;
    logic signed [cordw-1:0] posx_r;
    logic signed [cordw-1:0] posy_r;
    logic [rgb_w-1:0] colr_r;
    logic [spr_size-1:0] bmp_r [spr_size];

    logic sel_ctrl, sel_posx, sel_posy, sel_colr, sel_bmp;
    logic mapped;
    logic setup, access;
    logic [apb_aw-1:0] bmp_off;
    logic [spr_aw-1:0] bmp_row;
    logic [31:0] rd_val;

    // address decode
    assign sel_ctrl = (paddr == reg_ctrl);
    assign sel_posx = (paddr == reg_posx);
    assign sel_posy = (paddr == reg_posy);
    assign sel_colr = (paddr == reg_colr);
    assign bmp_off  = paddr - reg_bmp0;
    assign sel_bmp  = (paddr[1:0] == 2'b00) && (paddr >= reg_bmp0)
                    && (bmp_off < apb_aw'(4 * spr_size));
    assign bmp_row  = bmp_off[2 +: spr_aw];     // word index into the bitmap
    assign mapped   = sel_ctrl | sel_posx | sel_posy | sel_colr | sel_bmp;

    assign setup  = psel && !penable;
    assign access = psel && penable;
    assign pready = 1'b1;                       // zero wait states

    // read mux zero-extends each register to the bus
    always_comb begin
        rd_val = '0;
        if (sel_ctrl) rd_val[0] = en_r;
        if (sel_posx) rd_val[cordw-1:0] = posx_r;
        if (sel_posy) rd_val[cordw-1:0] = posy_r;
        if (sel_colr) rd_val[rgb_w-1:0] = colr_r;
        if (sel_bmp)  rd_val[spr_size-1:0] = bmp_r[bmp_row];
    end

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            en_r   <= 1'b0;
            posx_r <= '0;
            posy_r <= '0;
            colr_r <= '0;
            for (int i = 0; i < spr_size; i++) bmp_r[i] <= '0;
        end else if (access && pwrite) begin  // unmapped hits no select
            if (sel_ctrl) en_r <= pwdata[0];
            if (sel_posx) posx_r <= pwdata[cordw-1:0];
            if (sel_posy) posy_r <= pwdata[cordw-1:0];
            if (sel_colr) colr_r <= pwdata[rgb_w-1:0];
            if (sel_bmp)  bmp_r[bmp_row] <= pwdata[spr_size-1:0];
        end
    end

    // response captured in setup and presented during access
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            prdata  <= '0;
            pslverr <= 1'b0;
        end else begin
            pslverr <= setup && !mapped;
            if (setup) prdata <= pwrite ? '0 : rd_val;
        end
    end

    // shadow copies only move on the frame strobe
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            spr_en     <= 1'b0;
            spr_x      <= '0;
            spr_y      <= '0;
            spr_colr   <= '0;
            spr_bitmap <= '0;
        end else if (frame) begin
            spr_en   <= en_r;
            spr_x    <= posx_r;
            spr_y    <= posy_r;
            spr_colr <= colr_r;
            for (int i = 0; i < spr_size; i++) spr_bitmap[i*spr_size +: spr_size] <= bmp_r[i];
        end
    end

    apb_access_needs_sel: assert property (@(posedge clk_pix) disable iff (!rst_n)
        penable |-> psel);

endmodule

// ==== logic/sprite_engine.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sprite draw engine that fetches one bitmap row per line
// and shifts it out from spr_x at one pixel per clock
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module sprite_engine
    import sprite_pkg::*;
(
    input  wire logic clk_pix,
    input  wire logic rst_n,
    input  wire logic line,                        // line start strobe
    input  wire logic signed [cordw-1:0] sx,
    input  wire logic signed [cordw-1:0] sy,
    input  wire logic spr_en,
    input  wire logic signed [cordw-1:0] spr_x,
    input  wire logic signed [cordw-1:0] spr_y,
    input  wire logic [spr_size*spr_size-1:0] spr_bitmap,
    output logic spr_pix                           // one cycle after its sx
);

    typedef enum logic [1:0] {
        idle,       // nothing to draw on this line
        wait_pos,   // row fetched and waiting for sx
        draw        // shifting pixels out
    } state_t;

    state_t state;

    logic signed [cordw-1:0] dy;   // line offset into the sprite
    logic in_rows;
    logic [spr_aw-1:0] row_idx;
    logic [spr_size-1:0] row_bits;
    logic [spr_size-1:0] shift;    // current row with the next pixel in the msb
    logic [spr_aw:0] cnt;          // pixels sent so far
    logic load_row;
    logic start_draw;
    logic shifting;

    assign dy       = sy - spr_y;
    assign in_rows  = (dy >= 0) && (dy < spr_size);
    assign row_idx  = dy[spr_aw-1:0];
    assign row_bits = spr_bitmap[row_idx*spr_size +: spr_size];

    assign load_row   = line && spr_en && in_rows;
    assign start_draw = (state == wait_pos) && (sx == spr_x);
    assign shifting   = start_draw || (state == draw);

    // row shifter loads at line start and shifts while drawing
    always_ff @(posedge clk_pix) begin
        if (load_row) begin
            shift <= row_bits;
        end else if (shifting) begin
            shift <= {shift[spr_size-2:0], 1'b0};   // bit 7 goes out first
        end
    end

    // control
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            state   <= idle;
            cnt     <= '0;
            spr_pix <= 1'b0;
        end else begin
            spr_pix <= shifting && shift[spr_size-1];
            if (line) begin
                // every line restarts since a draw cut here lies off screen
                state <= load_row ? wait_pos : idle;
                cnt   <= '0;
            end else begin
                case (state)
                    wait_pos: begin
                        if (start_draw) begin
                            state <= draw;
                            cnt   <= (spr_aw+1)'(1);    // first pixel already out
                        end
                    end
                    draw: begin
                        if (cnt == (spr_aw+1)'(spr_size - 1)) begin
                            state <= idle;                // last pixel this cycle
                            cnt   <= '0;
                        end else begin
                            cnt <= cnt + 1'b1;
                        end
                    end
                    default: begin
                        cnt <= '0;
                    end
                endcase
            end
        end
    end

    draw_cnt_bound: assert property (@(posedge clk_pix) disable iff (!rst_n)
        cnt <= spr_size);

endmodule

// ==== logic/sprite_display.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sprite overlay top, apb config in, registered vga
// out, two cycles from coordinate to pixel
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module sprite_display
    import sprite_pkg::*;
#(
    parameter int h_res  = 640,
    parameter int h_fp   = 16,
    parameter int h_sync = 96,
    parameter int h_bp   = 48,
    parameter int v_res  = 480,
    parameter int v_fp   = 10,
    parameter int v_sync = 2,
    parameter int v_bp   = 33
) (
    input  wire logic clk_pix,
    input  wire logic rst_n,
    input  wire logic psel,
    input  wire logic penable,
    input  wire logic pwrite,
    input  wire logic [apb_aw-1:0] paddr,
    input  wire logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic pready,
    output logic pslverr,
    output logic vga_hsync,               // active high
    output logic vga_vsync,
    output logic vga_de,
    output logic [colr_w-1:0] vga_r,
    output logic [colr_w-1:0] vga_g,
    output logic [colr_w-1:0] vga_b
);

    logic signed [cordw-1:0] sx, sy;
    logic hsync, vsync, de, line, frame;
    logic spr_en;
    logic signed [cordw-1:0] spr_x, spr_y;
    logic [rgb_w-1:0] spr_colr;
    logic [spr_size*spr_size-1:0] spr_bitmap;
    logic spr_pix;
    logic hsync_d, vsync_d, de_d;         // lined up with spr_pix

    display_timings #(
        .h_res(h_res), .h_fp(h_fp), .h_sync(h_sync), .h_bp(h_bp),
        .v_res(v_res), .v_fp(v_fp), .v_sync(v_sync), .v_bp(v_bp)
    ) timings_inst (
        .clk_pix, .rst_n, .sx, .sy, .hsync, .vsync, .de, .line, .frame
    );

    sprite_regs regs_inst (
        .clk_pix, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata, .frame,
        .prdata, .pready, .pslverr, .spr_en, .spr_x, .spr_y, .spr_colr, .spr_bitmap
    );

    sprite_engine engine_inst (
        .clk_pix, .rst_n, .line, .sx, .sy, .spr_en, .spr_x, .spr_y, .spr_bitmap, .spr_pix
    );

    // one stage to match the engine, one more for the pins
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            hsync_d   <= 1'b0;
            vsync_d   <= 1'b0;
            de_d      <= 1'b0;
            vga_hsync <= 1'b0;
            vga_vsync <= 1'b0;
            vga_de    <= 1'b0;
            {vga_r, vga_g, vga_b} <= '0;
        end else begin
            hsync_d   <= hsync;
            vsync_d   <= vsync;
            de_d      <= de;
            vga_hsync <= hsync_d;
            vga_vsync <= vsync_d;
            vga_de    <= de_d;
            {vga_r, vga_g, vga_b} <= (de_d && spr_pix) ? spr_colr : '0;  // black outside
        end
    end

endmodule

// ==== tests/sprite_checker.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// video checker, rebuilds the raster position from de
// and vsync and compares every pixel with a sprite model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module sprite_checker
    import sprite_pkg::*;
#(
    parameter int h_res  = 32,
    parameter int h_sync = 4,
    parameter int h_tot  = 40,   // whole line in clocks
    parameter int v_res  = 12,
    parameter int v_sync = 2     // in lines
) (
    input wire logic clk_pix,
    input wire logic rst_n,
    input wire logic vga_hsync,
    input wire logic vga_vsync,
    input wire logic vga_de,
    input wire logic [colr_w-1:0] vga_r,
    input wire logic [colr_w-1:0] vga_g,
    input wire logic [colr_w-1:0] vga_b
);

    // pending model moves to active at vsync, like the shadow registers
    logic p_en = 1'b0;
    logic a_en = 1'b0;
    int p_x, p_y, a_x, a_y;
    logic [rgb_w-1:0] p_colr, a_colr;
    logic [spr_size*spr_size-1:0] p_bmp, a_bmp;   // row n at [8n+7:8n]

    int px_cnt, ln_cnt, hs_len, vs_len;           // rebuilt position, sync widths
    logic de_q, hs_q, vs_q, synced, chk_frame;
    int skip_left = 0;                            // frames to let pass first
    int chk_left = 0;                             // frames still to compare
    int err_cnt = 0;
    int test_base = 0;
    int tests_run = 0;
    int tests_failed = 0;

    function automatic logic [rgb_w-1:0] model_pix(input int x, input int y);
        int dx, dy;
        dx = x - a_x;
        dy = y - a_y;
        if (!a_en || dx < 0 || dx >= spr_size || dy < 0 || dy >= spr_size)
            return '0;
        return a_bmp[dy*spr_size + spr_size - 1 - dx] ? a_colr : '0;  // bit 7 leftmost
    endfunction

    task automatic check_val(input string sig, input int exp, input int act);
        if (exp != act) begin
            err_cnt++;
            $display("ERR %0t ns %0s: expected %0h, actual %0h", $time, sig, exp, act);
        end
    endtask

    task automatic set_model(input logic en, input int x, input int y,
                             input logic [rgb_w-1:0] colr,
                             input logic [spr_size*spr_size-1:0] bmp);
        p_en   = en;
        p_x    = x;
        p_y    = y;
        p_colr = colr;
        p_bmp  = bmp;
    endtask

    task automatic arm(input int skip, input int cnt);
        skip_left = skip;
        chk_left  = cnt;
    endtask

    function automatic bit busy();
        return (skip_left > 0) || (chk_left > 0);
    endfunction

    task automatic end_test(input string name);
        tests_run++;
        if (err_cnt == test_base) begin
            $display("test %0s: ok", name);
        end else begin
            tests_failed++;
            $display("test %0s: %0d errors", name, err_cnt - test_base);
        end
        test_base = err_cnt;
    endtask

    // outputs change on the rising edge, so look at them on the falling one
    always @(negedge clk_pix) begin
        if (!rst_n) begin
            px_cnt    = 0;
            ln_cnt    = 0;
            hs_len    = 0;
            vs_len    = 0;
            de_q      = 1'b0;
            hs_q      = 1'b0;
            vs_q      = 1'b0;
            synced    = 1'b0;
            chk_frame = 1'b0;
        end else begin
            if (vga_vsync && !vs_q) begin                  // new frame
                if (synced)
                    check_val("vga_de lines per frame", v_res, ln_cnt);
                if (chk_frame)
                    chk_left--;
                a_en      = p_en;
                a_x       = p_x;
                a_y       = p_y;
                a_colr    = p_colr;
                a_bmp     = p_bmp;
                chk_frame = (skip_left == 0) && (chk_left > 0);
                if (skip_left > 0)
                    skip_left--;
                synced = 1'b1;
                ln_cnt = 0;
            end
            if (vga_de) begin
                if (chk_frame)
                    check_val($sformatf("vga_rgb at x %0d y %0d", px_cnt, ln_cnt),
                              int'(model_pix(px_cnt, ln_cnt)), int'({vga_r, vga_g, vga_b}));
                px_cnt++;
            end else begin
                check_val("vga_rgb in blanking", 0, int'({vga_r, vga_g, vga_b}));
                if (de_q) begin                            // end of an active line
                    check_val("vga_de pixels per line", h_res, px_cnt);
                    ln_cnt++;
                    px_cnt = 0;
                end
            end
            if (vga_hsync) begin
                hs_len++;
            end else if (hs_q) begin
                check_val("vga_hsync width", h_sync, hs_len);
                hs_len = 0;
            end
            if (vga_vsync) begin
                vs_len++;
            end else if (vs_q) begin
                check_val("vga_vsync width in clocks", v_sync * h_tot, vs_len);
                vs_len = 0;
            end
            de_q = vga_de;
            hs_q = vga_hsync;
            vs_q = vga_vsync;
        end
    end

endmodule

// ==== tests/sprite_display_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the sprite overlay that runs seeded apb setup
// on a small raster while sprite_checker compares the video
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module sprite_display_tb;
    import sprite_pkg::*;

    localparam int h_res  = 32;
    localparam int h_fp   = 2;
    localparam int h_sync = 4;
    localparam int h_bp   = 2;
    localparam int v_res  = 12;
    localparam int v_fp   = 1;
    localparam int v_sync = 2;
    localparam int v_bp   = 1;
    localparam int h_tot  = h_res + h_fp + h_sync + h_bp;
    localparam int wait_limit = 4 * h_tot * (v_res + v_fp + v_sync + v_bp);  // four frames

    logic clk_pix, rst_n, psel, penable, pwrite;
    logic [apb_aw-1:0] paddr;
    logic [31:0] pwdata, prdata;
    logic pready, pslverr, vga_hsync, vga_vsync, vga_de;
    logic [colr_w-1:0] vga_r, vga_g, vga_b;
    integer seed;
    logic [31:0] exp_reg [12];      // last write per register after masking

    sprite_display #(
        .h_res(h_res), .h_fp(h_fp), .h_sync(h_sync), .h_bp(h_bp),
        .v_res(v_res), .v_fp(v_fp), .v_sync(v_sync), .v_bp(v_bp)
    ) uut (.*);

    sprite_checker #(
        .h_res(h_res), .h_sync(h_sync), .h_tot(h_tot), .v_res(v_res), .v_sync(v_sync)
    ) chk (
        .clk_pix, .rst_n, .vga_hsync, .vga_vsync, .vga_de, .vga_r, .vga_g, .vga_b
    );

    always #10 clk_pix = ~clk_pix;

    task automatic stop_on_timeout(input string what);
        $display("timeout at %0t ns, %0s", $time, what);
        $display("Verification failed");
        $finish;
    endtask

    // one apb transfer of a setup and an access cycle without wait states
    task automatic apb_xfer(input logic wr, input logic [apb_aw-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
        @(posedge clk_pix);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk_pix);
        penable <= 1'b1;
        @(negedge clk_pix);                   // mid access cycle
        rdata = prdata;
        err   = pslverr;
        chk.check_val("pready in access cycle", 1, int'(pready));
        @(posedge clk_pix);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    function automatic int rand_below(input int n);
        return {$random(seed)} % n;
    endfunction

    // register widths of enable, two positions, rgb and eight bitmap rows
    function automatic logic [31:0] reg_mask(input int idx);
        case (idx)
            0:       return 32'h1;
            1, 2:    return 32'hFFFF;
            3:       return 32'hFFF;
            default: return 32'hFF;
        endcase
    endfunction

    task automatic config_sprite(input logic en, input int x, input int y,
                                 input logic [rgb_w-1:0] colr, input logic [63:0] bmp);
        logic [31:0] vals [12];
        logic [31:0] rd;
        logic err;
        vals[0] = 32'(en);
        vals[1] = 32'(x);
        vals[2] = 32'(y);
        vals[3] = 32'(colr);
        for (int r = 0; r < spr_size; r++)
            vals[4+r] = 32'(bmp[r*spr_size +: spr_size]);
        for (int i = 0; i < 12; i++) begin
            apb_xfer(1'b1, apb_aw'(4*i), vals[i], rd, err);
            chk.check_val("pslverr on register write", 0, int'(err));
        end
        chk.set_model(en, x, y, colr, bmp);   // takes effect at the next vsync
    endtask

    task automatic wait_check_done();
        int n;
        n = 0;
        while (chk.busy() && n < wait_limit) begin
            @(posedge clk_pix);
            n++;
        end
        if (chk.busy())
            stop_on_timeout("sprite frame check never completed");
    endtask

    task automatic check_frames(input int skip, input int cnt);
        @(posedge clk_pix);
        chk.arm(skip, cnt);
        wait_check_done();
    endtask

    task automatic wait_vsync_rise();
        logic prev, seen;
        int n;
        n    = 0;
        seen = 1'b0;
        @(negedge clk_pix);
        prev = vga_vsync;
        while (!seen && n < wait_limit) begin
            @(negedge clk_pix);
            seen = vga_vsync && !prev;
            prev = vga_vsync;
            n++;
        end
        if (!seen)
            stop_on_timeout("vga_vsync never rose");
    endtask

    task automatic close_test(input string name);
        @(posedge clk_pix);
        chk.end_test(name);
    endtask

    initial begin
        logic [31:0] wval, rd;
        logic err;
        logic [rgb_w-1:0] colr;
        logic [63:0] bmp;
        logic [apb_aw-1:0] bad_addr [3];
        int x, y, x2, n;

        seed     = 30213;
        clk_pix  = 1'b0;
        rst_n    = 1'b0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        bad_addr = '{6'h30, 6'h3C, 6'h06};   // past the bitmap or off alignment
        repeat (4) @(posedge clk_pix);
        rst_n <= 1'b1;

        for (int i = 0; i < 12; i++) begin
            wval = $random(seed);
            apb_xfer(1'b1, apb_aw'(4*i), wval, rd, err);
            chk.check_val("pslverr on register write", 0, int'(err));
            exp_reg[i] = wval & reg_mask(i);
            apb_xfer(1'b0, apb_aw'(4*i), 32'd0, rd, err);
            chk.check_val("pslverr on register read", 0, int'(err));
            chk.check_val($sformatf("prdata at 0x%02h", 4*i), int'(exp_reg[i]), int'(rd));
        end
        close_test("register readback");

        for (int i = 0; i < 3; i++) begin
            apb_xfer(1'b1, bad_addr[i], $random(seed), rd, err);
            chk.check_val("pslverr on unmapped write", 1, int'(err));
            apb_xfer(1'b0, bad_addr[i], 32'd0, rd, err);
            chk.check_val("pslverr on unmapped read", 1, int'(err));
            chk.check_val("prdata on unmapped read", 0, int'(rd));
        end
        for (int i = 0; i < 12; i++) begin
            apb_xfer(1'b0, apb_aw'(4*i), 32'd0, rd, err);
            chk.check_val($sformatf("prdata at 0x%02h", 4*i), int'(exp_reg[i]), int'(rd));
        end
        close_test("unmapped address");

        wait_vsync_rise();                    // widths and counts checked all along
        wait_vsync_rise();
        close_test("raster timing");

        x    = rand_below(h_res - spr_size + 1);
        y    = rand_below(v_res - spr_size + 1);
        colr = rgb_w'($random(seed));
        bmp  = {$random(seed), $random(seed)};
        config_sprite(1'b1, x, y, colr, bmp);
        check_frames(1, 1);
        close_test("sprite drawing");

        config_sprite(1'b0, x, y, colr, '1);  // full block that stays disabled
        check_frames(1, 1);
        config_sprite(1'b1, h_res - 3, rand_below(v_res - spr_size + 1), colr, bmp);
        check_frames(1, 1);
        config_sprite(1'b1, rand_below(h_res - spr_size + 1), v_res - 3, colr, bmp);
        check_frames(1, 1);
        close_test("disable and clipping");

        x2 = (x + 1 + rand_below(h_res - spr_size)) % (h_res - spr_size + 1);  // never x
        config_sprite(1'b1, x, 2, colr, bmp);
        @(posedge clk_pix);
        chk.arm(1, 2);
        n = 0;
        while (!(chk.chk_frame && chk.chk_left == 2 && chk.ln_cnt >= 4) && n < wait_limit) begin
            @(posedge clk_pix);
            n++;
        end
        if (n >= wait_limit)
            stop_on_timeout("first checked frame never reached its middle");
        apb_xfer(1'b1, reg_posx, 32'(x2), rd, err);  // sprite rows still being drawn
        chk.set_model(1'b1, x2, 2, colr, bmp);
        wait_check_done();
        close_test("frame sync update");

        @(posedge clk_pix);
        $display("tests %0d, failed %0d, errors %0d",
                 chk.tests_run, chk.tests_failed, chk.err_cnt);
        if (chk.err_cnt == 0 && chk.tests_failed == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== sprite_display.f ====
logic/sprite_pkg.sv
logic/display_timings.sv
logic/sprite_regs.sv
logic/sprite_engine.sv
logic/sprite_display.sv
tests/sprite_checker.sv
tests/sprite_display_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the sprite overlay testbench with verilator and runs it
# exit status is nonzero unless the run reports a pass
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -Wno-fatal \
        --top-module sprite_display_tb -f sprite_display.f -o sprite_sim \
    && ./obj_dir/sprite_sim | tee /dev/stderr | grep -q "Verification passed" \
    && echo "simulation ok" \
    || { echo "simulation did not pass"; exit 1; }
